/* design/fir_pkg.sv */
package fir_pkg;

	// stream widths
	localparam int SAMPLE_WIDTH = 20;
	localparam int COEF_WIDTH = 16;
	localparam int ACC_WIDTH = 40;
	localparam int PAIR_WIDTH = SAMPLE_WIDTH + 1;
	localparam int PROD_WIDTH = PAIR_WIDTH + COEF_WIDTH;

	// filter shape
	localparam int NUM_TAPS = 9;
	localparam int NUM_PAIRS = (NUM_TAPS + 1) / 2;
	localparam int CENTRE_TAP = NUM_PAIRS - 1;
	localparam int COEF_SHIFT = 15;
	localparam int NUM_BANKS = 3;

	// output queue
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic signed [PAIR_WIDTH-1:0] pair_sum_t;
	typedef logic signed [COEF_WIDTH-1:0] coef_t;
	typedef logic [1:0] cutoff_t;
	typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;

	// saturation limits of the output word
	localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH - 1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH - 1){1'b0}}};

	// outer pair first, centre tap last
	// 2 * (c0 + c1 + c2 + c3) + c4 = 32768, unity gain after COEF_SHIFT
	localparam coef_t coef_banks [NUM_BANKS][NUM_PAIRS] = '{
		'{16'sd1024, 16'sd2560, 16'sd4096, 16'sd5632, 16'sd6144},
		'{16'sd256, 16'sd1280, 16'sd3840, 16'sd7168, 16'sd7680},
		'{-16'sd1024, 16'sd0, 16'sd4608, 16'sd8192, 16'sd9216}
	};

	// codes 0 and 3 share the lowest cutoff bank
	function automatic bank_sel_t cutoff_to_bank(cutoff_t code);
		bank_sel_t bank;
		case (code)
			2'd1: bank = 2'd1;
			2'd2: bank = 2'd2;
			default: bank = 2'd0;
		endcase
		return bank;
	endfunction

	// one sample on the input port
	typedef struct packed {
		sample_t sample;
		logic bypass;
		cutoff_t cutoff;
	} sample_beat_t;

	// folded sums, sum[CENTRE_TAP] holds the centre sample alone
	typedef struct packed {
		pair_sum_t [NUM_PAIRS-1:0] sum;
		sample_t centre;
		logic bypass;
		cutoff_t cutoff;
	} tap_pairs_t;

endpackage

/* design/fir_tap_line.sv */
module fir_tap_line
	import fir_pkg::*;
(
	input logic clk,
	input logic reset,

	input sample_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,

	output tap_pairs_t pairs,
	output logic pairs_valid,
	input logic pairs_ready
);

	// eight stored samples, the newest one arrives on in_beat
	sample_t taps [NUM_TAPS-1];
	sample_t next_line [NUM_TAPS];
	tap_pairs_t next_pairs;
	logic take;

	assign in_ready = !pairs_valid || pairs_ready;
	assign take = in_valid && in_ready;

	// delay line as it looks after this beat is accepted
	always_comb begin
		next_line[0] = in_beat.sample;
		for (int i = 1; i < NUM_TAPS; i++) begin
			next_line[i] = taps[i-1];
		end
	end

	// fold symmetric taps so the MAC needs only five multipliers
	always_comb begin
		for (int i = 0; i < CENTRE_TAP; i++) begin
			next_pairs.sum[i] = pair_sum_t'(next_line[i]) +
				pair_sum_t'(next_line[NUM_TAPS-1-i]);
		end
		next_pairs.sum[CENTRE_TAP] = pair_sum_t'(next_line[CENTRE_TAP]);
		next_pairs.centre = next_line[CENTRE_TAP];
		next_pairs.bypass = in_beat.bypass;
		next_pairs.cutoff = in_beat.cutoff;
	end

	// history starts from silence
	always_ff @(posedge clk) begin
		if (reset) begin
			pairs_valid <= 1'b0;
			for (int i = 0; i < NUM_TAPS - 1; i++) begin
				taps[i] <= '0;
			end
		end else begin
			if (in_ready) begin
				pairs_valid <= in_valid;
			end
			if (take) begin
				for (int i = 0; i < NUM_TAPS - 1; i++) begin
					taps[i] <= next_line[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pairs <= next_pairs;
		end
	end

endmodule

/* design/fir_mac.sv */
module fir_mac
	import fir_pkg::*;
(
	input logic clk,
	input logic reset,

	input tap_pairs_t pairs,
	input logic pairs_valid,
	output logic pairs_ready,

	output logic signed [SAMPLE_WIDTH-1:0] result,
	output logic result_valid,
	input logic result_ready
);

	bank_sel_t bank;
	logic signed [PROD_WIDTH-1:0] products [NUM_PAIRS];
	logic signed [ACC_WIDTH-1:0] acc;
	logic signed [ACC_WIDTH-1:0] scaled;
	logic [ACC_WIDTH-SAMPLE_WIDTH:0] top_bits;
	logic overflow;
	sample_t filtered;
	sample_t next_result;
	logic take;

	assign pairs_ready = !result_valid || result_ready;
	assign take = pairs_valid && pairs_ready;

	// one multiplier per folded pair
	always_comb begin
		bank = cutoff_to_bank(pairs.cutoff);
		for (int i = 0; i < NUM_PAIRS; i++) begin
			products[i] = $signed(pairs.sum[i]) * coef_banks[bank][i];
		end
	end

	always_comb begin
		acc = '0;
		for (int i = 0; i < NUM_PAIRS; i++) begin
			acc = acc + products[i];
		end
	end

	// back to sample scale
	assign scaled = acc >>> COEF_SHIFT;

	// fits in 20 bits only if everything above bit 18 matches the sign
	assign top_bits = scaled[ACC_WIDTH-1:SAMPLE_WIDTH-1];
	assign overflow = !((&top_bits) || !(|top_bits));

	always_comb begin
		if (overflow) begin
			filtered = scaled[ACC_WIDTH-1] ? SAMPLE_MIN : SAMPLE_MAX;
		end else begin
			filtered = scaled[SAMPLE_WIDTH-1:0];
		end
	end

	// bypass keeps the group delay of four samples
	assign next_result = pairs.bypass ? pairs.centre : filtered;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else if (pairs_ready) begin
			result_valid <= pairs_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			result <= next_result;
		end
	end

endmodule

/* design/sample_fifo.sv */
module sample_fifo
	import fir_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic signed [SAMPLE_WIDTH-1:0] wr_data,
	input logic wr_valid,
	output logic wr_ready,

	output logic signed [SAMPLE_WIDTH-1:0] rd_data,
	output logic rd_valid,
	input logic rd_ready
);

	sample_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
	logic [FIFO_COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	// wraps at the last entry, so any depth works
	function automatic logic [FIFO_PTR_WIDTH-1:0] ptr_next(
		logic [FIFO_PTR_WIDTH-1:0] ptr
	);
		if (ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// a read frees a slot in the same cycle
	assign wr_ready = (count != FIFO_COUNT_WIDTH'(FIFO_DEPTH)) || rd_ready;
	assign rd_valid = count != '0;
	assign rd_data = mem[rd_ptr];

	assign push = wr_valid && wr_ready;
	assign pop = rd_valid && rd_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// simultaneous push and pop leaves the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

/* design/filter_top.sv */
module filter_top
	import fir_pkg::*;
(
	input logic clk,
	input logic reset,

	input sample_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,

	output logic signed [SAMPLE_WIDTH-1:0] out_sample,
	output logic out_valid,
	input logic out_ready
);

	// tap line to MAC
	tap_pairs_t pairs;
	logic pairs_valid;
	logic pairs_ready;

	// MAC to output queue
	logic signed [SAMPLE_WIDTH-1:0] result;
	logic result_valid;
	logic result_ready;

	fir_tap_line i_tap_line (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.pairs(pairs),
		.pairs_valid(pairs_valid),
		.pairs_ready(pairs_ready)
	);

	fir_mac i_mac (
		.clk(clk),
		.reset(reset),
		.pairs(pairs),
		.pairs_valid(pairs_valid),
		.pairs_ready(pairs_ready),
		.result(result),
		.result_valid(result_valid),
		.result_ready(result_ready)
	);

	// absorbs back-pressure from the sink
	sample_fifo i_fifo (
		.clk(clk),
		.reset(reset),
		.wr_data(result),
		.wr_valid(result_valid),
		.wr_ready(result_ready),
		.rd_data(out_sample),
		.rd_valid(out_valid),
		.rd_ready(out_ready)
	);

endmodule

/* dv/filter_top_asserts.sv */
module filter_top_asserts
	import fir_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic pairs_valid,
	input logic result_valid,
	input logic result_ready,
	input logic signed [SAMPLE_WIDTH-1:0] out_sample,
	input logic out_valid,
	input logic out_ready
);

	logic [FIFO_COUNT_WIDTH-1:0] fill;

	// occupancy seen from the queue's two ports
	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
		end else if (result_valid && result_ready && !(out_valid && out_ready)) begin
			fill <= fill + 1'b1;
		end else if (out_valid && out_ready && !(result_valid && result_ready)) begin
			fill <= fill - 1'b1;
		end
	end

	// held output stays put under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_sample))
		else $error("out_sample changed while the sink stalled");

	assert property (@(posedge clk)
		$fell(reset) |-> !out_valid && !pairs_valid && !result_valid)
		else $error("a valid was high in the cycle after reset");

	// full queue, stalled sink and two held beats must stall the input
	assert property (@(posedge clk) disable iff (reset)
		fill == FIFO_COUNT_WIDTH'(FIFO_DEPTH) && !out_ready && result_valid && pairs_valid
			|-> !in_ready)
		else $error("in_ready high while the whole path is full");

endmodule

bind filter_top filter_top_asserts i_asserts (
	.clk(clk),
	.reset(reset),
	.in_ready(in_ready),
	.pairs_valid(pairs_valid),
	.result_valid(result_valid),
	.result_ready(result_ready),
	.out_sample(out_sample),
	.out_valid(out_valid),
	.out_ready(out_ready)
);

/* dv/filter_top_tb.sv */
module filter_top_tb
	import fir_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_SAMPLE = 20;
	localparam int NUM_PHASES = 11;

	typedef enum logic [1:0] {PAT_IMPULSE, PAT_POS_FULL, PAT_NEG_FULL, PAT_RANDOM} pattern_t;

	typedef struct packed {
		logic [15:0] count;
		logic reset_first;
		logic bypass;
		cutoff_t cutoff;
		pattern_t pattern;
		logic random_ready;
	} phase_t;

	// count, reset first, bypass, cutoff, pattern, random out_ready
	phase_t phases [NUM_PHASES] = '{
		'{16'd20, 1'b0, 1'b1, 2'd0, PAT_RANDOM, 1'b0},
		'{16'd12, 1'b1, 1'b0, 2'd0, PAT_IMPULSE, 1'b0},
		'{16'd30, 1'b0, 1'b0, 2'd1, PAT_RANDOM, 1'b0},
		'{16'd30, 1'b0, 1'b0, 2'd2, PAT_RANDOM, 1'b0},
		'{16'd30, 1'b0, 1'b0, 2'd3, PAT_RANDOM, 1'b0},
		'{16'd12, 1'b0, 1'b0, 2'd2, PAT_NEG_FULL, 1'b0},
		'{16'd12, 1'b0, 1'b0, 2'd2, PAT_POS_FULL, 1'b0},
		'{16'd12, 1'b0, 1'b0, 2'd2, PAT_NEG_FULL, 1'b0},
		'{16'd40, 1'b0, 1'b0, 2'd1, PAT_RANDOM, 1'b1},
		'{16'd12, 1'b1, 1'b0, 2'd2, PAT_RANDOM, 1'b1},
		'{16'd24, 1'b0, 1'b1, 2'd0, PAT_RANDOM, 1'b1}
	};

	logic clk = 1'b0;
	logic reset = 1'b1;
	sample_beat_t in_beat = '0;
	logic in_valid = 1'b0;
	logic in_ready;
	logic signed [SAMPLE_WIDTH-1:0] out_sample;
	logic out_valid;
	logic out_ready = 1'b0;

	integer seed = 32'he5e8;
	logic ready_random = 1'b0;
	sample_t history [NUM_TAPS];
	sample_t exp_q [$];

	filter_top i_filter_top (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_sample(out_sample),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string name, input longint actual, input longint expected);
		if (actual !== expected) begin
			$display("CHECK FAILED time=%0t signal=%s actual=%0d expected=%0d",
				$time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// expected output for the current history, newest sample at index 0
	function automatic sample_t expected_output(logic bypass, cutoff_t code);
		int bank;
		int k;
		longint acc;
		longint scaled;
		if (bypass) begin
			return history[4];
		end
		bank = (code == 2'd1) ? 1 : (code == 2'd2) ? 2 : 0;
		acc = 0;
		for (int i = 0; i < NUM_TAPS; i++) begin
			k = (i < NUM_PAIRS) ? i : NUM_TAPS - 1 - i;
			acc += longint'(history[i]) * longint'(coef_banks[bank][k]);
		end
		scaled = acc >>> COEF_SHIFT;
		if (scaled > longint'(SAMPLE_MAX)) begin
			return SAMPLE_MAX;
		end
		if (scaled < longint'(SAMPLE_MIN)) begin
			return SAMPLE_MIN;
		end
		return sample_t'(scaled);
	endfunction

	function automatic sample_beat_t make_beat(phase_t ph, int index);
		sample_beat_t beat;
		beat.bypass = ph.bypass;
		beat.cutoff = ph.cutoff;
		case (ph.pattern)
			PAT_IMPULSE: beat.sample = (index == 0) ? sample_t'(32768) : '0;
			PAT_POS_FULL: beat.sample = SAMPLE_MAX;
			PAT_NEG_FULL: beat.sample = SAMPLE_MIN;
			default: beat.sample = sample_t'($random(seed));
		endcase
		return beat;
	endfunction

	function automatic int total_samples();
		int total;
		total = 0;
		for (int p = 0; p < NUM_PHASES; p++) begin
			total += int'(phases[p].count);
		end
		return total;
	endfunction

	function automatic int watchdog_cycles();
		int cycles;
		cycles = RESET_CYCLES + CYCLES_PER_SAMPLE * total_samples();
		for (int p = 0; p < NUM_PHASES; p++) begin
			if (phases[p].reset_first) begin
				cycles += RESET_CYCLES;
			end
		end
		return cycles;
	endfunction

	task automatic apply_reset();
		for (int i = 0; i < NUM_TAPS; i++) begin
			history[i] = '0;
		end
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic drive_beat(input sample_beat_t beat);
		in_beat <= beat;
		in_valid <= 1'b1;
		@(posedge clk);
		while (!in_ready) @(posedge clk);
	endtask

	task automatic wait_drain();
		@(posedge clk);
		while (exp_q.size() != 0) @(posedge clk);
	endtask

	always @(posedge clk) begin
		int draw;
		if (ready_random) begin
			draw = $random(seed);
			out_ready <= draw[0];
		end else begin
			out_ready <= 1'b1;
		end
	end

	// reference model and scoreboard
	always @(posedge clk) begin
		if (!reset && in_valid && in_ready) begin
			for (int i = NUM_TAPS - 1; i > 0; i--) begin
				history[i] = history[i-1];
			end
			history[0] = in_beat.sample;
			exp_q.push_back(expected_output(in_beat.bypass, in_beat.cutoff));
		end
		if (!reset && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("an output arrived at time %0t with no input waiting for it", $time);
				$display("STATUS: FAIL");
				$fatal(1, "unexpected output");
			end
			check_value("out_sample", out_sample, exp_q.pop_front());
		end
	end

	initial begin
		int limit;
		limit = watchdog_cycles();
		repeat (limit) @(posedge clk);
		$display("timeout: outputs stopped arriving within %0d cycles", limit);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		apply_reset();
		for (int p = 0; p < NUM_PHASES; p++) begin
			// mid-stream reset, history is not zero here
			if (phases[p].reset_first) begin
				wait_drain();
				apply_reset();
			end
			ready_random = phases[p].random_ready;
			for (int j = 0; j < int'(phases[p].count); j++) begin
				drive_beat(make_beat(phases[p], j));
			end
			in_valid <= 1'b0;
		end
		ready_random = 1'b0;
		wait_drain();
		// a duplicated beat would still be on its way out
		repeat (FIFO_DEPTH + 3) @(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* filter_chain.f */
design/fir_pkg.sv
design/fir_tap_line.sv
design/fir_mac.sv
design/sample_fifo.sv
design/filter_top.sv
dv/filter_top_asserts.sv
dv/filter_top_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module filter_top_tb -f filter_chain.f -o sim_filter

status=0
./obj_dir/sim_filter > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
